//--- include/ray_consts.svh
`ifndef RAY_CONSTS_SVH
`define RAY_CONSTS_SVH

// screen
`define CORDW 5
`define SCREEN_W 16
`define SCREEN_H 12

// fixed point, signed 16 bit with 8 fraction bits
`define FRAC_BITS 8

// world units per pixel, 0.25
`define PIX_SCALE (1 << (`FRAC_BITS - 2))

// scene and march limits
`define BOX_HALF (1 << `FRAC_BITS)
// 0.2 rounds down to 51/256
`define EPSILON 51
`define MAX_DIST (16 << `FRAC_BITS)
`define ITR_PER_LOOP 6
`define NUM_LOOPS 3
`define MAX_STEPS (`ITR_PER_LOOP * `NUM_LOOPS)
`define RING_LEN (2 * `ITR_PER_LOOP)

// colour rule
`define DEPTH_SHIFT 4
`define COLOR_OFFSET 125

// output side
`define OUT_FIFO_DEPTH 4
`define OUT_CREDITS 4

`endif

//--- hw/ray_pkg.sv
`default_nettype none

`include "ray_consts.svh"

package ray_pkg;

    // world value, 8 fraction bits
    typedef logic signed [15:0] fix_t;

    // screen coordinate
    typedef logic [`CORDW-1:0] pix_t;

    typedef logic [5:0] step_t;

    typedef logic [7:0] color_t;

    // where a ray is in its life
    typedef enum logic [2:0] {
        RAY_EMPTY     = 3'd0,
        RAY_MARCHING  = 3'd1,
        RAY_HIT       = 3'd2,
        RAY_MISS      = 3'd3,
        RAY_EXHAUSTED = 3'd4
    } ray_status_e;

endpackage

`default_nettype wire

//--- hw/pixel_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "ray_consts.svh"

module pixel_scan (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          i_take,
    input  wire ray_pkg::fix_t i_eye_x,
    input  wire ray_pkg::fix_t i_eye_y,
    input  wire ray_pkg::fix_t i_eye_z,
    output ray_pkg::pix_t      o_pix_x,
    output ray_pkg::pix_t      o_pix_y,
    output ray_pkg::fix_t      o_org_x,
    output ray_pkg::fix_t      o_org_y,
    output ray_pkg::fix_t      o_org_z
);

    localparam int HALF_W = `SCREEN_W / 2;
    localparam int HALF_H = `SCREEN_H / 2;

    ray_pkg::pix_t x;
    ray_pkg::pix_t y;
    ray_pkg::fix_t off_x;
    ray_pkg::fix_t off_y;

    // raster counters, move on only when the ring took the ray
    always_ff @(posedge clk) begin
        if (reset) begin
            x <= '0;
            y <= '0;
        end else if (i_take) begin
            if (x == ray_pkg::pix_t'(`SCREEN_W - 1)) begin
                x <= '0;
                if (y == ray_pkg::pix_t'(`SCREEN_H - 1)) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // signed pixel offset from screen centre
    assign off_x = ray_pkg::fix_t'(x) - ray_pkg::fix_t'(HALF_W);
    assign off_y = ray_pkg::fix_t'(y) - ray_pkg::fix_t'(HALF_H);

    // orthographic ray, origin shifted in the screen plane
    assign o_org_x = i_eye_x + off_x * ray_pkg::fix_t'(`PIX_SCALE);
    assign o_org_y = i_eye_y + off_y * ray_pkg::fix_t'(`PIX_SCALE);
    assign o_org_z = i_eye_z;

    assign o_pix_x = x;
    assign o_pix_y = y;

endmodule

`default_nettype wire

//--- hw/march_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ray_consts.svh"

module march_stage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ray_pkg::ray_status_e i_status,
    input  wire ray_pkg::pix_t        i_pix_x,
    input  wire ray_pkg::pix_t        i_pix_y,
    input  wire ray_pkg::fix_t        i_pt_x,
    input  wire ray_pkg::fix_t        i_pt_y,
    input  wire ray_pkg::fix_t        i_pt_z,
    input  wire ray_pkg::fix_t        i_depth,
    input  wire ray_pkg::step_t       i_steps,
    output ray_pkg::ray_status_e      o_status,
    output ray_pkg::pix_t             o_pix_x,
    output ray_pkg::pix_t             o_pix_y,
    output ray_pkg::fix_t             o_pt_x,
    output ray_pkg::fix_t             o_pt_y,
    output ray_pkg::fix_t             o_pt_z,
    output ray_pkg::fix_t             o_depth,
    output ray_pkg::step_t            o_steps
);

    ray_pkg::fix_t q_x, q_y, q_z, q_max;

    ray_pkg::ray_status_e s1_status;
    ray_pkg::pix_t s1_pix_x, s1_pix_y;
    ray_pkg::fix_t s1_pt_x, s1_pt_y, s1_pt_z, s1_depth, s1_dist;
    ray_pkg::step_t s1_steps;

    ray_pkg::fix_t new_z, new_depth;
    ray_pkg::step_t new_steps;
    logic s1_hit;

    // chebyshev box distance
    always_comb begin
        q_x = (i_pt_x < 0 ? -i_pt_x : i_pt_x) - ray_pkg::fix_t'(`BOX_HALF);
        q_y = (i_pt_y < 0 ? -i_pt_y : i_pt_y) - ray_pkg::fix_t'(`BOX_HALF);
        q_z = (i_pt_z < 0 ? -i_pt_z : i_pt_z) - ray_pkg::fix_t'(`BOX_HALF);
        q_max = (q_x > q_y) ? q_x : q_y;
        q_max = (q_z > q_max) ? q_z : q_max;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_status <= ray_pkg::RAY_EMPTY;
        end else begin
            s1_status <= i_status;
        end
    end

    always_ff @(posedge clk) begin
        s1_pix_x <= i_pix_x;
        s1_pix_y <= i_pix_y;
        s1_pt_x  <= i_pt_x;
        s1_pt_y  <= i_pt_y;
        s1_pt_z  <= i_pt_z;
        s1_depth <= i_depth;
        s1_steps <= i_steps;
        s1_dist  <= q_max;
    end

    // step along +z by the safe distance
    assign new_z     = s1_pt_z + s1_dist;
    assign new_depth = s1_depth + s1_dist;
    assign new_steps = s1_steps + 1'b1;
    assign s1_hit    = s1_dist < ray_pkg::fix_t'(`EPSILON);

    always_ff @(posedge clk) begin
        if (reset) begin
            o_status <= ray_pkg::RAY_EMPTY;
        end else if (s1_status != ray_pkg::RAY_MARCHING) begin
            o_status <= s1_status;
        end else if (s1_hit) begin
            o_status <= ray_pkg::RAY_HIT;
        end else if (new_depth >= ray_pkg::fix_t'(`MAX_DIST)) begin
            o_status <= ray_pkg::RAY_MISS;
        end else if (new_steps >= ray_pkg::step_t'(`MAX_STEPS)) begin
            o_status <= ray_pkg::RAY_EXHAUSTED;
        end else begin
            o_status <= ray_pkg::RAY_MARCHING;
        end
    end

    always_ff @(posedge clk) begin
        o_pix_x <= s1_pix_x;
        o_pix_y <= s1_pix_y;
        o_pt_x  <= s1_pt_x;
        o_pt_y  <= s1_pt_y;
        o_pt_z  <= s1_pt_z;
        o_depth <= s1_depth;
        o_steps <= s1_steps;
        if (s1_status == ray_pkg::RAY_MARCHING) begin
            o_steps <= new_steps;
            // a hit keeps the point where the surface was found
            if (!s1_hit) begin
                o_pt_z  <= new_z;
                o_depth <= new_depth;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/march_ring.sv
`timescale 1ns/1ps
`default_nettype none

`include "ray_consts.svh"

module march_ring (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire ray_pkg::pix_t i_pix_x,
    input  wire ray_pkg::pix_t i_pix_y,
    input  wire ray_pkg::fix_t i_org_x,
    input  wire ray_pkg::fix_t i_org_y,
    input  wire ray_pkg::fix_t i_org_z,
    input  wire logic          i_ret_ready,
    output logic               o_take,
    output logic               o_ret_valid,
    output ray_pkg::pix_t      o_ret_x,
    output ray_pkg::pix_t      o_ret_y,
    output ray_pkg::ray_status_e o_ret_status,
    output ray_pkg::fix_t      o_ret_depth
);

    localparam int LAST = `ITR_PER_LOOP;

    // links between stages, index 0 is the entry, LAST is the ring tail
    ray_pkg::ray_status_e stat  [0:LAST];
    ray_pkg::pix_t        pix_x [0:LAST];
    ray_pkg::pix_t        pix_y [0:LAST];
    ray_pkg::fix_t        pt_x  [0:LAST];
    ray_pkg::fix_t        pt_y  [0:LAST];
    ray_pkg::fix_t        pt_z  [0:LAST];
    ray_pkg::fix_t        depth [0:LAST];
    ray_pkg::step_t       steps [0:LAST];

    ray_pkg::ray_status_e ent_status;
    ray_pkg::pix_t        ent_pix_x, ent_pix_y;
    ray_pkg::fix_t        ent_pt_x, ent_pt_y, ent_pt_z, ent_depth;
    ray_pkg::step_t       ent_steps;

    logic tail_done;
    logic retire;

    assign tail_done = (stat[LAST] == ray_pkg::RAY_HIT) ||
                       (stat[LAST] == ray_pkg::RAY_MISS) ||
                       (stat[LAST] == ray_pkg::RAY_EXHAUSTED);

    // finished rays leave only when the output side has room
    assign retire = tail_done && i_ret_ready;
    assign o_take = (stat[LAST] == ray_pkg::RAY_EMPTY) || retire;

    // entry mux: fresh ray into a free slot, otherwise go round again
    always_comb begin
        if (o_take) begin
            ent_status = ray_pkg::RAY_MARCHING;
            ent_pix_x  = i_pix_x;
            ent_pix_y  = i_pix_y;
            ent_pt_x   = i_org_x;
            ent_pt_y   = i_org_y;
            ent_pt_z   = i_org_z;
            ent_depth  = '0;
            ent_steps  = '0;
        end else begin
            ent_status = stat[LAST];
            ent_pix_x  = pix_x[LAST];
            ent_pix_y  = pix_y[LAST];
            ent_pt_x   = pt_x[LAST];
            ent_pt_y   = pt_y[LAST];
            ent_pt_z   = pt_z[LAST];
            ent_depth  = depth[LAST];
            ent_steps  = steps[LAST];
        end
    end

    assign stat[0]  = ent_status;
    assign pix_x[0] = ent_pix_x;
    assign pix_y[0] = ent_pix_y;
    assign pt_x[0]  = ent_pt_x;
    assign pt_y[0]  = ent_pt_y;
    assign pt_z[0]  = ent_pt_z;
    assign depth[0] = ent_depth;
    assign steps[0] = ent_steps;

    for (genvar n = 0; n < LAST; n++) begin : g_stage
        march_stage u_stage (
            .clk      (clk),
            .reset    (reset),
            .i_status (stat[n]),
            .i_pix_x  (pix_x[n]),
            .i_pix_y  (pix_y[n]),
            .i_pt_x   (pt_x[n]),
            .i_pt_y   (pt_y[n]),
            .i_pt_z   (pt_z[n]),
            .i_depth  (depth[n]),
            .i_steps  (steps[n]),
            .o_status (stat[n+1]),
            .o_pix_x  (pix_x[n+1]),
            .o_pix_y  (pix_y[n+1]),
            .o_pt_x   (pt_x[n+1]),
            .o_pt_y   (pt_y[n+1]),
            .o_pt_z   (pt_z[n+1]),
            .o_depth  (depth[n+1]),
            .o_steps  (steps[n+1])
        );
    end

    assign o_ret_valid  = retire;
    assign o_ret_x      = pix_x[LAST];
    assign o_ret_y      = pix_y[LAST];
    assign o_ret_status = stat[LAST];
    assign o_ret_depth  = depth[LAST];

endmodule

`default_nettype wire

//--- hw/shade_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "ray_consts.svh"

module shade_out (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 i_ret_valid,
    input  wire ray_pkg::pix_t        i_ret_x,
    input  wire ray_pkg::pix_t        i_ret_y,
    input  wire ray_pkg::ray_status_e i_ret_status,
    input  wire ray_pkg::fix_t        i_ret_depth,
    input  wire logic                 i_credit,
    output logic                      o_ret_ready,
    output logic                      o_pix_valid,
    output ray_pkg::pix_t             o_pix_x,
    output ray_pkg::pix_t             o_pix_y,
    output ray_pkg::color_t           o_red,
    output ray_pkg::color_t           o_green,
    output ray_pkg::color_t           o_blue
);

    localparam int PTR_W = $clog2(`OUT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`OUT_FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

    ray_pkg::pix_t   fifo_x [`OUT_FIFO_DEPTH];
    ray_pkg::pix_t   fifo_y [`OUT_FIFO_DEPTH];
    ray_pkg::color_t fifo_r [`OUT_FIFO_DEPTH];
    ray_pkg::color_t fifo_g [`OUT_FIFO_DEPTH];
    ray_pkg::color_t fifo_b [`OUT_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;
    logic [15:0] depth_scaled;
    ray_pkg::color_t red, green, blue;
    logic pop;

    // status to colour, red fades with depth
    assign depth_scaled = i_ret_depth >> `DEPTH_SHIFT;

    always_comb begin
        red   = '0;
        green = '0;
        blue  = '0;
        case (i_ret_status)
            ray_pkg::RAY_HIT: begin
                red  = 8'd255 - depth_scaled[7:0] + 8'(`COLOR_OFFSET);
                blue = 8'd255;
            end
            ray_pkg::RAY_EXHAUSTED: green = 8'd255;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_ret_valid) begin
            fifo_x[wr_ptr] <= i_ret_x;
            fifo_y[wr_ptr] <= i_ret_y;
            fifo_r[wr_ptr] <= red;
            fifo_g[wr_ptr] <= green;
            fifo_b[wr_ptr] <= blue;
        end
    end

    // head goes out whenever a credit is held
    assign pop = (fill != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= CRD_W'(`OUT_CREDITS);
        end else begin
            if (i_ret_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`OUT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`OUT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_ret_valid, pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: ;
            endcase
            // returned credit saturates at the start value
            if (i_credit && !pop && credits != CRD_W'(`OUT_CREDITS)) begin
                credits <= credits + 1'b1;
            end else if (!i_credit && pop) begin
                credits <= credits - 1'b1;
            end
        end
    end

    assign o_ret_ready = (fill != CNT_W'(`OUT_FIFO_DEPTH));
    assign o_pix_valid = pop;
    assign o_pix_x     = fifo_x[rd_ptr];
    assign o_pix_y     = fifo_y[rd_ptr];
    assign o_red       = fifo_r[rd_ptr];
    assign o_green     = fifo_g[rd_ptr];
    assign o_blue      = fifo_b[rd_ptr];

endmodule

`default_nettype wire

//--- hw/raymarch_top.sv
`timescale 1ns/1ps
`default_nettype none

module raymarch_top (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire ray_pkg::fix_t i_eye_x,
    input  wire ray_pkg::fix_t i_eye_y,
    input  wire ray_pkg::fix_t i_eye_z,
    input  wire logic          i_credit,
    output logic               o_pix_valid,
    output ray_pkg::pix_t      o_pix_x,
    output ray_pkg::pix_t      o_pix_y,
    output ray_pkg::color_t    o_red,
    output ray_pkg::color_t    o_green,
    output ray_pkg::color_t    o_blue
);

    // scan to ring
    logic take;
    ray_pkg::pix_t scan_x, scan_y;
    ray_pkg::fix_t org_x, org_y, org_z;

    // ring to output side
    logic ret_valid, ret_ready;
    ray_pkg::pix_t ret_x, ret_y;
    ray_pkg::ray_status_e ret_status;
    ray_pkg::fix_t ret_depth;

    pixel_scan u_scan (
        .clk     (clk),
        .reset   (reset),
        .i_take  (take),
        .i_eye_x (i_eye_x),
        .i_eye_y (i_eye_y),
        .i_eye_z (i_eye_z),
        .o_pix_x (scan_x),
        .o_pix_y (scan_y),
        .o_org_x (org_x),
        .o_org_y (org_y),
        .o_org_z (org_z)
    );

    march_ring u_ring (
        .clk          (clk),
        .reset        (reset),
        .i_pix_x      (scan_x),
        .i_pix_y      (scan_y),
        .i_org_x      (org_x),
        .i_org_y      (org_y),
        .i_org_z      (org_z),
        .i_ret_ready  (ret_ready),
        .o_take       (take),
        .o_ret_valid  (ret_valid),
        .o_ret_x      (ret_x),
        .o_ret_y      (ret_y),
        .o_ret_status (ret_status),
        .o_ret_depth  (ret_depth)
    );

    shade_out u_shade (
        .clk          (clk),
        .reset        (reset),
        .i_ret_valid  (ret_valid),
        .i_ret_x      (ret_x),
        .i_ret_y      (ret_y),
        .i_ret_status (ret_status),
        .i_ret_depth  (ret_depth),
        .i_credit     (i_credit),
        .o_ret_ready  (ret_ready),
        .o_pix_valid  (o_pix_valid),
        .o_pix_x      (o_pix_x),
        .o_pix_y      (o_pix_y),
        .o_red        (o_red),
        .o_green      (o_green),
        .o_blue       (o_blue)
    );

endmodule

`default_nettype wire

//--- tb/raymarch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ray_consts.svh"

module raymarch_tb;

    localparam int NPIX = `SCREEN_W * `SCREEN_H;
    localparam int LIMIT = NPIX * (`MAX_STEPS + 2) * `RING_LEN;

    logic clk;
    logic reset;
    logic i_credit;
    ray_pkg::fix_t i_eye_x, i_eye_y, i_eye_z;
    logic o_pix_valid;
    ray_pkg::pix_t o_pix_x, o_pix_y;
    ray_pkg::color_t o_red, o_green, o_blue;

    integer seed = 93796;
    int cycle;
    int phase;
    int sent, returned, delay;
    int seen_cnt, delivered, hits, misses, rst_cycles;
    bit seen [NPIX];
    int inj_cnt [NPIX];
    int dlv_cnt [NPIX];

    raymarch_top UUT (
        .clk         (clk),
        .reset       (reset),
        .i_eye_x     (i_eye_x),
        .i_eye_y     (i_eye_y),
        .i_eye_z     (i_eye_z),
        .i_credit    (i_credit),
        .o_pix_valid (o_pix_valid),
        .o_pix_x     (o_pix_x),
        .o_pix_y     (o_pix_y),
        .o_red       (o_red),
        .o_green     (o_green),
        .o_blue      (o_blue)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // step-by-step march of one pixel with the eye at (0, 0, ez)
    function automatic void march_model(input int px, input int py, input int ez,
                                        output ray_pkg::ray_status_e st, output int depth);
        int ox, oy, z, d, steps;
        ox = (px - `SCREEN_W / 2) * 64;
        oy = (py - `SCREEN_H / 2) * 64;
        z = ez;
        depth = 0;
        steps = 0;
        st = ray_pkg::RAY_MARCHING;
        while (st == ray_pkg::RAY_MARCHING) begin
            d = ((ox < 0) ? -ox : ox) - 256;
            if (((oy < 0) ? -oy : oy) - 256 > d) d = ((oy < 0) ? -oy : oy) - 256;
            if (((z < 0) ? -z : z) - 256 > d) d = ((z < 0) ? -z : z) - 256;
            steps++;
            if (d < 51) begin
                st = ray_pkg::RAY_HIT;
            end else begin
                z += d;
                depth += d;
                if (depth >= 16 * 256) st = ray_pkg::RAY_MISS;
                else if (steps >= 18) st = ray_pkg::RAY_EXHAUSTED;
            end
        end
    endfunction

    // red falls by depth/16 and is offset by 125 modulo 256
    function automatic int hit_red(input int depth);
        return (255 - ((depth / 16) % 256) + 125) % 256;
    endfunction

    task automatic check_chan(input string name, input int exp, input int act);
        assert (exp == act)
        else fail_run($sformatf("Fail %s: expected 0x%02h, got 0x%02h", name, exp, act));
    endtask

    // consumer returns credits and holds them back in stretches
    always @(negedge clk) begin
        i_credit <= 1'b0;
        if (reset) begin
            returned <= 0;
            delay <= 0;
        end else if (sent - returned > 0 && (cycle % 300) >= 80) begin
            if (delay == 0) begin
                i_credit <= 1'b1;
                returned <= returned + 1;
                delay <= $random(seed) & 7;
            end else begin
                delay <= delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        ray_pkg::ray_status_e st;
        int depth, idx, ix;
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            fail_run($sformatf("timeout in phase %0d with %0d pixels never delivered",
                               phase, NPIX - seen_cnt));
        end
        if (reset) begin
            rst_cycles <= rst_cycles + 1;
            assert (rst_cycles == 0 || o_pix_valid == 1'b0)
            else fail_run("pixel valid went high during reset");
            sent <= 0;
            seen_cnt <= 0;
            delivered <= 0;
            hits <= 0;
            misses <= 0;
            for (int i = 0; i < NPIX; i++) begin
                seen[i] = 1'b0;
                inj_cnt[i] = 0;
                dlv_cnt[i] = 0;
            end
        end else begin
            rst_cycles <= 0;
            if (UUT.take) begin
                ix = int'(UUT.scan_y) * `SCREEN_W + int'(UUT.scan_x);
                inj_cnt[ix] = inj_cnt[ix] + 1;
            end
            if (o_pix_valid) begin
                idx = int'(o_pix_y) * `SCREEN_W + int'(o_pix_x);
                assert (sent + 1 - returned <= `OUT_CREDITS)
                else fail_run("more pixels outstanding than credits");
                sent <= sent + 1;
                delivered <= delivered + 1;
                dlv_cnt[idx] = dlv_cnt[idx] + 1;
                assert (dlv_cnt[idx] <= inj_cnt[idx])
                else fail_run($sformatf("pixel %0d,%0d delivered twice", o_pix_x, o_pix_y));
                if (!seen[idx]) begin
                    seen[idx] = 1'b1;
                    seen_cnt <= seen_cnt + 1;
                end
                march_model(int'(o_pix_x), int'(o_pix_y), int'(i_eye_z), st, depth);
                check_chan("o_red", (st == ray_pkg::RAY_HIT) ? hit_red(depth) : 0,
                           int'(o_red));
                check_chan("o_green", (st == ray_pkg::RAY_EXHAUSTED) ? 255 : 0,
                           int'(o_green));
                check_chan("o_blue", (st == ray_pkg::RAY_HIT) ? 255 : 0, int'(o_blue));
                // on the cube face means a hit while the eye is near enough
                if (phase != 3 && o_pix_x >= 4 && o_pix_x <= 12 &&
                    o_pix_y >= 2 && o_pix_y <= 10) begin
                    check_chan("o_blue", 255, int'(o_blue));
                end
                if (phase == 1 && o_pix_x == 8 && o_pix_y == 6) begin
                    check_chan("o_red", hit_red(3 << 8), int'(o_red));
                end
                if (o_blue == 8'd255) hits <= hits + 1;
                if ({o_red, o_green, o_blue} == 24'd0) misses <= misses + 1;
            end
        end
    end

    task automatic restart(input int ez);
        @(negedge clk);
        reset = 1'b1;
        i_eye_z = ray_pkg::fix_t'(ez);
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    initial begin
        cycle = 0;
        rst_cycles = 0;
        reset = 1'b1;
        i_credit = 1'b0;
        i_eye_x = '0;
        i_eye_y = '0;
        i_eye_z = ray_pkg::fix_t'(-(4 << 8));

        // eye close to the cube with a full frame under back-pressure
        phase = 1;
        restart(-(4 << 8));
        while (seen_cnt < NPIX) @(negedge clk);
        assert (hits > 0 && misses > 0)
        else fail_run("first frame lacks a hit pixel or a black pixel");

        // eye far back where the cube must still be hit
        phase = 2;
        restart(-(15 << 8));
        while (seen_cnt < NPIX) @(negedge clk);
        assert (hits > 0) else fail_run("far camera never hit the cube");

        // short run with the eye very far back
        phase = 3;
        restart(-(40 << 8));
        while (delivered < 48) @(negedge clk);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/ray_pkg.sv
hw/pixel_scan.sv
hw/march_stage.sv
hw/march_ring.sv
hw/shade_out.sv
hw/raymarch_top.sv
tb/raymarch_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module raymarch_tb

sim:
	verilator --binary --timing --assert -f flist.f --top-module raymarch_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vraymarch_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
